/* hdl/ConfRegs.sv */
`timescale 1ns/1ns
`default_nettype none

module ConfRegs
   import ReqArbPkg::*;
#(
   parameter int RingEntries = 16
) (
   input  wire logic                            clock,
   input  wire logic                            reset,
   input  wire confReqT                         confReq_i,
   output logic                                 confWaitRequest_o,
   output logic [31:0]                          confReadData_o,
   output logic [63:0]                          irrqBase_o,
   output logic [63:0]                          cqBase_o,
   input  wire logic [$clog2(RingEntries)-1:0]  irrqIndex_i,
   input  wire logic [$clog2(RingEntries)-1:0]  cqIndex_i
);

   logic        fullWrite;
   logic        readReq;
   logic        readPending;
   logic [31:0] readMux;

   // Partial writes are dropped
   assign fullWrite = confReq_i.chipSelect & confReq_i.write &
                      (confReq_i.byteEnable == FullWordEnable);
   assign readReq   = confReq_i.chipSelect & confReq_i.read;

   // One wait cycle per read, data follows in the next cycle
   assign confWaitRequest_o = readReq & ~readPending;

   always_comb begin
      case (confReq_i.address)
         RegIrrqBaseHi: readMux = irrqBase_o[63:32];
         RegIrrqBaseLo: readMux = irrqBase_o[31:0];
         RegCqBaseHi:   readMux = cqBase_o[63:32];
         RegCqBaseLo:   readMux = cqBase_o[31:0];
         RegIndex:      readMux = {16'(cqIndex_i), 16'(irrqIndex_i)};
         default:       readMux = '0;
      endcase
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         irrqBase_o <= '0;
         cqBase_o   <= '0;
      end else if (fullWrite) begin
         case (confReq_i.address)
            RegIrrqBaseHi: irrqBase_o[63:32] <= confReq_i.writeData;
            RegIrrqBaseLo: irrqBase_o[31:0]  <= confReq_i.writeData;
            RegCqBaseHi:   cqBase_o[63:32]   <= confReq_i.writeData;
            RegCqBaseLo:   cqBase_o[31:0]    <= confReq_i.writeData;
            default:       ;
         endcase
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         readPending    <= 1'b0;
         confReadData_o <= '0;
      end else begin
         if (readReq && !readPending) begin
            readPending    <= 1'b1;
            confReadData_o <= readMux;
         end else begin
            // Requester drops or reissues after the data cycle
            readPending <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/QueueWriter.sv */
`timescale 1ns/1ns
`default_nettype none

module QueueWriter
   import ReqArbPkg::*;
#(
   parameter int  RingEntries = 16,
   parameter type entryT      = irrqEntryT
) (
   input  wire logic                            clock,
   input  wire logic                            reset,
   input  wire logic [63:0]                     base_i,
   input  wire entryT                           entry_i,
   input  wire logic                            empty_i,
   output logic                                 pop_o,
   output hostWrT                               hostWr_o,
   input  wire logic                            waitRequest_i,
   output logic [$clog2(RingEntries)-1:0]       index_o
);

   localparam int IndexW = $clog2(RingEntries);
   localparam int EntryW = $bits(entryT);
   localparam int HighW  = EntryW - 32;
   // One enable bit per byte of the upper payload part
   localparam int HighBytes = (HighW + 7) / 8;
   localparam logic [3:0] FirstEnable = 4'((5'd1 << HighBytes) - 5'd1);

   logic [EntryW-1:0] entryBits;
   logic [31:0]       highWord;
   logic [63:0]       slotAddr;
   logic              busy;
   logic              second;
   logic              accepted;
   logic [63:0]       beatAddr;
   logic [31:0]       beatData;
   logic [3:0]        beatEnable;

   assign entryBits = entry_i;
   assign highWord  = 32'(entryBits[EntryW-1:32]);
   // Two words per ring slot
   assign slotAddr  = base_i + {{(63 - IndexW){1'b0}}, index_o, 1'b0};

   assign accepted = busy & ~waitRequest_i;
   assign pop_o    = accepted & second;

   assign hostWr_o.chipSelect = busy;
   assign hostWr_o.address    = beatAddr;
   assign hostWr_o.writeData  = beatData;
   assign hostWr_o.byteEnable = beatEnable;

   // Beat sequencer and ring index
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         busy    <= 1'b0;
         second  <= 1'b0;
         index_o <= '0;
      end else if (!busy) begin
         busy   <= ~empty_i;
         second <= 1'b0;
      end else if (accepted) begin
         if (!second) begin
            second <= 1'b1;
         end else begin
            busy    <= 1'b0;
            second  <= 1'b0;
            index_o <= index_o + 1'b1;
         end
      end
   end

   // Beat payload, held while the host stalls
   always_ff @(posedge clock) begin
      if (!busy && !empty_i) begin
         beatAddr   <= slotAddr;
         beatData   <= highWord;
         beatEnable <= FirstEnable;
      end else if (accepted && !second) begin
         beatAddr   <= beatAddr + 64'd1;
         beatData   <= entryBits[31:0];
         beatEnable <= FullWordEnable;
      end
   end

endmodule

`default_nettype wire

/* hdl/ReqArbPkg.sv */
`default_nettype none

package ReqArbPkg;

   // Interrupt request record
   typedef struct packed {
      logic [23:0] tag;
      logic [31:0] info;
   } irrqEntryT;

   // Completion record
   typedef struct packed {
      logic [7:0]  status;
      logic [31:0] info;
   } cqEntryT;

   // Configuration slave request, Avalon style
   typedef struct packed {
      logic        chipSelect;
      logic        write;
      logic        read;
      logic [7:0]  address;
      logic [31:0] writeData;
      logic [3:0]  byteEnable;
   } confReqT;

   // One host write beat, word addressed
   typedef struct packed {
      logic        chipSelect;
      logic [63:0] address;
      logic [31:0] writeData;
      logic [3:0]  byteEnable;
   } hostWrT;

   // Configuration register map
   localparam logic [7:0] RegIrrqBaseHi = 8'h10;
   localparam logic [7:0] RegIrrqBaseLo = 8'h14;
   localparam logic [7:0] RegCqBaseHi   = 8'h20;
   localparam logic [7:0] RegCqBaseLo   = 8'h24;
   // CQ index in the upper half, IRRQ index in the lower half
   localparam logic [7:0] RegIndex      = 8'h30;

   // Second beat of every record carries a full word
   localparam logic [3:0] FullWordEnable = 4'hf;

endpackage

`default_nettype wire

/* hdl/ReqArbTop.sv */
`timescale 1ns/1ns
`default_nettype none

module ReqArbTop
   import ReqArbPkg::*;
#(
   parameter int FifoDepth   = 8,
   parameter int RingEntries = 16
) (
   input  wire logic      clock,
   input  wire logic      reset,
   input  wire confReqT   confReq_i,
   output logic           confWaitRequest_o,
   output logic [31:0]    confReadData_o,
   input  wire logic      irrqValid_i,
   input  wire irrqEntryT irrqEntry_i,
   output logic           irrqReady_o,
   input  wire logic      cqValid_i,
   input  wire cqEntryT   cqEntry_i,
   output logic           cqReady_o,
   output hostWrT         hostWr_o,
   input  wire logic      hostWaitRequest_i
);

   localparam int IndexW = $clog2(RingEntries);

   logic [63:0]       irrqBase;
   logic [63:0]       cqBase;
   logic [IndexW-1:0] irrqIndex;
   logic [IndexW-1:0] cqIndex;
   irrqEntryT         irrqHead;
   cqEntryT           cqHead;
   logic              irrqFull;
   logic              cqFull;
   logic              irrqEmpty;
   logic              cqEmpty;
   logic              irrqPop;
   logic              cqPop;
   hostWrT            irrqWr;
   hostWrT            cqWr;
   logic              irrqWait;
   logic              cqWait;

   assign irrqReady_o = ~irrqFull;
   assign cqReady_o   = ~cqFull;

   ConfRegs #(.RingEntries(RingEntries)) i_confRegs (
      .clock, .reset, .confReq_i, .confWaitRequest_o, .confReadData_o,
      .irrqBase_o(irrqBase), .cqBase_o(cqBase),
      .irrqIndex_i(irrqIndex), .cqIndex_i(cqIndex)
   );

   ReqFifo #(.FifoDepth(FifoDepth), .entryT(irrqEntryT)) i_irrqFifo (
      .clock, .reset, .push_i(irrqValid_i), .data_i(irrqEntry_i),
      .pop_i(irrqPop), .data_o(irrqHead), .full_o(irrqFull), .empty_o(irrqEmpty)
   );

   ReqFifo #(.FifoDepth(FifoDepth), .entryT(cqEntryT)) i_cqFifo (
      .clock, .reset, .push_i(cqValid_i), .data_i(cqEntry_i),
      .pop_i(cqPop), .data_o(cqHead), .full_o(cqFull), .empty_o(cqEmpty)
   );

   QueueWriter #(.RingEntries(RingEntries), .entryT(irrqEntryT)) i_irrqWriter (
      .clock, .reset, .base_i(irrqBase), .entry_i(irrqHead), .empty_i(irrqEmpty),
      .pop_o(irrqPop), .hostWr_o(irrqWr), .waitRequest_i(irrqWait), .index_o(irrqIndex)
   );

   QueueWriter #(.RingEntries(RingEntries), .entryT(cqEntryT)) i_cqWriter (
      .clock, .reset, .base_i(cqBase), .entry_i(cqHead), .empty_i(cqEmpty),
      .pop_o(cqPop), .hostWr_o(cqWr), .waitRequest_i(cqWait), .index_o(cqIndex)
   );

   WriteArbiter i_arbiter (
      .clock, .reset, .irrqWr_i(irrqWr), .cqWr_i(cqWr),
      .irrqWait_o(irrqWait), .cqWait_o(cqWait),
      .hostWr_o, .hostWaitRequest_i
   );

endmodule

`default_nettype wire

/* hdl/ReqFifo.sv */
`timescale 1ns/1ns
`default_nettype none

module ReqFifo #(
   parameter int  FifoDepth = 8,
   parameter type entryT    = logic [31:0]
) (
   input  wire logic  clock,
   input  wire logic  reset,
   input  wire logic  push_i,
   input  wire entryT data_i,
   input  wire logic  pop_i,
   output entryT      data_o,
   output logic       full_o,
   output logic       empty_o
);

   localparam int AddrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
   localparam int CntW  = $clog2(FifoDepth + 1);

   entryT            mem [FifoDepth];
   logic [AddrW-1:0] wrPtr;
   logic [AddrW-1:0] rdPtr;
   logic [CntW-1:0]  count;
   logic             doPush;
   logic             doPop;

   assign full_o  = (count == CntW'(FifoDepth));
   assign empty_o = (count == '0);
   assign doPush  = push_i & ~full_o;
   assign doPop   = pop_i & ~empty_o;

   // Head entry is always on the output
   assign data_o = mem[rdPtr];

   always_ff @(posedge clock) begin
      if (doPush) begin
         mem[wrPtr] <= data_i;
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doPush) begin
            wrPtr <= (wrPtr == AddrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
         end
         if (doPop) begin
            rdPtr <= (rdPtr == AddrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
         end
         if (doPush && !doPop) begin
            count <= count + 1'b1;
         end else if (doPop && !doPush) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/WriteArbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module WriteArbiter
   import ReqArbPkg::*;
(
   input  wire logic   clock,
   input  wire logic   reset,
   input  wire hostWrT irrqWr_i,
   input  wire hostWrT cqWr_i,
   output logic        irrqWait_o,
   output logic        cqWait_o,
   output hostWrT      hostWr_o,
   input  wire logic   hostWaitRequest_i
);

   // Grant select is 0 for IRRQ and 1 for CQ
   logic   grantValid;
   logic   grantSel;
   logic   locked;
   logic   lastServed;
   hostWrT selWr;
   logic   accepted;
   logic   lastBeat;

   assign selWr    = grantSel ? cqWr_i : irrqWr_i;
   assign accepted = grantValid & selWr.chipSelect & ~hostWaitRequest_i;
   // Only the second beat carries a full word enable
   assign lastBeat = (selWr.byteEnable == FullWordEnable);

   always_comb begin
      hostWr_o            = selWr;
      hostWr_o.chipSelect = selWr.chipSelect & grantValid;
   end

   // Stalled unless granted
   assign irrqWait_o = ~(grantValid & ~grantSel) | hostWaitRequest_i;
   assign cqWait_o   = ~(grantValid & grantSel) | hostWaitRequest_i;

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         grantValid <= 1'b0;
         grantSel   <= 1'b0;
         locked     <= 1'b0;
         lastServed <= 1'b1;
      end else if (!grantValid) begin
         if (irrqWr_i.chipSelect && cqWr_i.chipSelect) begin
            grantValid <= 1'b1;
            grantSel   <= ~lastServed;
         end else if (irrqWr_i.chipSelect) begin
            grantValid <= 1'b1;
            grantSel   <= 1'b0;
         end else if (cqWr_i.chipSelect) begin
            grantValid <= 1'b1;
            grantSel   <= 1'b1;
         end
      end else if (accepted && lastBeat) begin
         // Pair done, arbitrate again next cycle
         grantValid <= 1'b0;
         locked     <= 1'b0;
         lastServed <= grantSel;
      end else if (accepted) begin
         locked <= 1'b1;
      end else if (!locked && !selWr.chipSelect) begin
         grantValid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it into a log and judge the log

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ReqArbTb -f sim.f \
   -o ReqArbSim > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }

./obj_dir/ReqArbSim > "$LOG" 2>&1
cat "$LOG"

grep -q "Verification failed" "$LOG" && exit 1
grep -q "Verification passed" "$LOG" || exit 1
exit 0

/* sim.f */
hdl/ReqArbPkg.sv
hdl/ReqFifo.sv
hdl/ConfRegs.sv
hdl/QueueWriter.sv
hdl/WriteArbiter.sv
hdl/ReqArbTop.sv
testbench/ReqArbTb.sv

/* testbench/ReqArbTb.sv */
`timescale 1ns/1ns
`default_nettype none

module ReqArbTb
   import ReqArbPkg::*;
();

   localparam int FifoDepth   = 8;
   localparam int RingEntries = 16;
   localparam int IrrqRecords = 24;
   localparam int CqRecords   = 20;
   localparam int MixRecords  = 30;
   // Flood phase fills both FIFOs once
   localparam int RecordsSent = IrrqRecords + CqRecords + 2 * MixRecords + 2 * FifoDepth;
   localparam int TimeoutCycles = 4 * (RecordsSent * 2 * 3) + 500;

   logic        clock;
   logic        reset;
   confReqT     confReq;
   logic        confWaitRequest;
   logic [31:0] confReadData;
   logic        irrqValid;
   irrqEntryT   irrqEntry;
   logic        irrqReady;
   logic        cqValid;
   cqEntryT     cqEntry;
   logic        cqReady;
   hostWrT      hostWr;
   logic        hostWaitRequest;

   int          seed = 32'h15da_9363;
   int          cycleCount = 0;
   logic [63:0] irrqBase;
   logic [63:0] cqBase;

   // Stimulus control, written by the main sequence
   int   irrqTarget = 0;
   int   cqTarget = 0;
   logic holdWait = 1'b0;
   logic flood = 1'b0;

   // Reference model state
   irrqEntryT   irrqQ[$];
   cqEntryT     cqQ[$];
   int          irrqCount = 0;
   int          cqCount = 0;
   int          irrqIdx = 0;
   int          cqIdx = 0;
   logic        pairActive = 1'b0;
   int          pairStream = 0;
   logic [63:0] secondAddr;
   logic [31:0] secondData;
   logic        expectValid = 1'b0;
   int          expectStream = 0;
   logic        stallSeen = 1'b0;
   hostWrT      stalledWr;

   ReqArbTop #(.FifoDepth(FifoDepth), .RingEntries(RingEntries)) i_dut (
      .clock, .reset,
      .confReq_i(confReq), .confWaitRequest_o(confWaitRequest),
      .confReadData_o(confReadData),
      .irrqValid_i(irrqValid), .irrqEntry_i(irrqEntry), .irrqReady_o(irrqReady),
      .cqValid_i(cqValid), .cqEntry_i(cqEntry), .cqReady_o(cqReady),
      .hostWr_o(hostWr), .hostWaitRequest_i(hostWaitRequest)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   task automatic abortRun();
      $display("Verification failed");
      $fatal(1, "first error ends the run");
   endtask

   task automatic raiseError(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      abortRun();
   endtask

   task automatic flagMismatch(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
      $display("mismatch at %0t ns: %s expected 0x%0h actual 0x%0h",
               $time, name, expected, actual);
      abortRun();
   endtask

   readWaitOnce: assert property (@(posedge clock) disable iff (!reset)
      confWaitRequest |=> !confWaitRequest)
      else raiseError("configuration wait request held longer than one cycle");

   task automatic writeConf(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] enables);
      @(negedge clock);
      confReq = '0;
      confReq.chipSelect = 1'b1;
      confReq.write = 1'b1;
      confReq.address = addr;
      confReq.writeData = data;
      confReq.byteEnable = enables;
      @(posedge clock);
      assert (!confWaitRequest)
         else flagMismatch("confWaitRequest_o on write", 0, confWaitRequest);
      @(negedge clock);
      confReq = '0;
   endtask

   task automatic readCheck(input logic [7:0] addr, input logic [31:0] expected);
      int waitCycles;
      waitCycles = 0;
      @(negedge clock);
      confReq = '0;
      confReq.chipSelect = 1'b1;
      confReq.read = 1'b1;
      confReq.address = addr;
      confReq.byteEnable = 4'hf;
      @(posedge clock);
      while (confWaitRequest) begin
         waitCycles++;
         @(posedge clock);
      end
      assert (waitCycles == 1)
         else flagMismatch("confWaitRequest_o cycles per read", 1, waitCycles);
      assert (confReadData == expected)
         else flagMismatch($sformatf("confReadData_o at 0x%02h", addr), expected, confReadData);
      @(negedge clock);
      confReq = '0;
   endtask

   // Host side scoreboard for one accepted beat
   task automatic checkBeat();
      irrqEntryT   irrqRec;
      cqEntryT     cqRec;
      logic [63:0] firstAddr;
      logic [31:0] firstData;
      int          stream;
      if (!pairActive) begin
         if (hostWr.byteEnable == 4'b0111) begin
            stream = 0;
         end else if (hostWr.byteEnable == 4'b0001) begin
            stream = 1;
         end else begin
            raiseError($sformatf("first beat carries byte enable %b of no stream",
                                 hostWr.byteEnable));
         end
         if (expectValid) begin
            assert (stream == expectStream)
               else flagMismatch("stream granted after a pair", expectStream, stream);
         end
         if (stream == 0) begin
            assert (irrqQ.size() > 0) else raiseError("IRRQ beat with no record accepted");
            irrqRec = irrqQ.pop_front();
            firstAddr = irrqBase + 64'(2 * irrqIdx);
            firstData = {8'h00, irrqRec.tag};
            secondData = irrqRec.info;
         end else begin
            assert (cqQ.size() > 0) else raiseError("CQ beat with no record accepted");
            cqRec = cqQ.pop_front();
            firstAddr = cqBase + 64'(2 * cqIdx);
            firstData = {24'h0, cqRec.status};
            secondData = cqRec.info;
         end
         assert (hostWr.address == firstAddr)
            else flagMismatch("hostWr_o.address", firstAddr, hostWr.address);
         assert (hostWr.writeData == firstData)
            else flagMismatch("hostWr_o.writeData", firstData, hostWr.writeData);
         secondAddr = firstAddr + 64'd1;
         pairStream = stream;
         pairActive = 1'b1;
      end else begin
         assert (hostWr.address == secondAddr)
            else flagMismatch("hostWr_o.address", secondAddr, hostWr.address);
         assert (hostWr.writeData == secondData)
            else flagMismatch("hostWr_o.writeData", secondData, hostWr.writeData);
         assert (hostWr.byteEnable == 4'hf)
            else flagMismatch("hostWr_o.byteEnable", 4'hf, hostWr.byteEnable);
         pairActive = 1'b0;
         // A waiting record on the other stream wins the next pair
         if (pairStream == 0) begin
            irrqIdx = (irrqIdx + 1) % RingEntries;
            expectValid = (cqQ.size() > 0);
            expectStream = 1;
         end else begin
            cqIdx = (cqIdx + 1) % RingEntries;
            expectValid = (irrqQ.size() > 0);
            expectStream = 0;
         end
      end
   endtask

   always @(posedge clock) begin
      if (reset) begin
         if (stallSeen) begin
            assert (hostWr == stalledWr)
               else flagMismatch("hostWr_o under wait request", stalledWr, hostWr);
         end
         stallSeen = hostWr.chipSelect && hostWaitRequest;
         stalledWr = hostWr;
         if (hostWr.chipSelect && !hostWaitRequest) begin
            checkBeat();
         end
         if (irrqValid && irrqReady) begin
            irrqQ.push_back(irrqEntry);
            irrqCount++;
         end
         if (cqValid && cqReady) begin
            cqQ.push_back(cqEntry);
            cqCount++;
         end
      end
   end

   always @(posedge clock) begin
      cycleCount++;
      if (cycleCount > TimeoutCycles) begin
         $display("Timeout after %0d cycles with traffic still pending", cycleCount);
         abortRun();
      end
   end

   // Request and host wait drivers
   always @(negedge clock) begin
      hostWaitRequest = holdWait | (($unsigned($random(seed)) % 3) == 0);
      irrqValid = 1'b0;
      cqValid = 1'b0;
      if (irrqCount < irrqTarget && (flood || ($random(seed) % 2) == 0)) begin
         irrqValid = 1'b1;
         irrqEntry.tag = 24'($random(seed));
         irrqEntry.info = $random(seed);
      end
      if (cqCount < cqTarget && (flood || ($random(seed) % 2) == 0)) begin
         cqValid = 1'b1;
         cqEntry.status = 8'($random(seed));
         cqEntry.info = $random(seed);
      end
   end

   task automatic waitDrained();
      @(negedge clock);
      while (irrqCount < irrqTarget || cqCount < cqTarget ||
             irrqQ.size() != 0 || cqQ.size() != 0 || pairActive) begin
         @(negedge clock);
      end
   endtask

   task automatic runTraffic(input int irrqNum, input int cqNum);
      @(negedge clock);
      irrqTarget <= irrqCount + irrqNum;
      cqTarget <= cqCount + cqNum;
      waitDrained();
   endtask

   // Host stalls, both FIFOs fill and stop accepting
   task automatic floodCheck();
      int irrqStart;
      int cqStart;
      @(negedge clock);
      irrqStart = irrqCount;
      cqStart = cqCount;
      holdWait <= 1'b1;
      flood <= 1'b1;
      irrqTarget <= irrqCount + FifoDepth + 8;
      cqTarget <= cqCount + FifoDepth + 8;
      @(negedge clock);
      while (irrqReady || cqReady) begin
         @(negedge clock);
      end
      assert (irrqCount - irrqStart == FifoDepth)
         else flagMismatch("IRRQ records before irrqReady_o fell", FifoDepth, irrqCount - irrqStart);
      assert (cqCount - cqStart == FifoDepth)
         else flagMismatch("CQ records before cqReady_o fell", FifoDepth, cqCount - cqStart);
      repeat (8) begin
         @(negedge clock);
         assert (!irrqReady && !cqReady) else raiseError("reqReady rose while the host stalled");
      end
      irrqTarget <= irrqCount;
      cqTarget <= cqCount;
      holdWait <= 1'b0;
      flood <= 1'b0;
      waitDrained();
   endtask

   initial begin
      reset = 1'b0;
      confReq = '0;
      irrqValid = 1'b0;
      irrqEntry = '0;
      cqValid = 1'b0;
      cqEntry = '0;
      hostWaitRequest = 1'b0;
      irrqBase = {$random(seed), $random(seed)};
      cqBase = {$random(seed), $random(seed)};
      repeat (16) @(posedge clock);
      @(negedge clock);
      reset = 1'b1;
      @(negedge clock);
      assert (!hostWr.chipSelect)
         else flagMismatch("hostWr_o.chipSelect after reset", 0, hostWr.chipSelect);
      assert (!confWaitRequest)
         else flagMismatch("confWaitRequest_o after reset", 0, confWaitRequest);
      assert (irrqReady && cqReady) else raiseError("reqReady low after reset");

      writeConf(RegIrrqBaseHi, irrqBase[63:32], 4'hf);
      writeConf(RegIrrqBaseLo, irrqBase[31:0], 4'hf);
      writeConf(RegCqBaseHi, cqBase[63:32], 4'hf);
      writeConf(RegCqBaseLo, cqBase[31:0], 4'hf);
      // Partial write must leave the register alone
      writeConf(RegCqBaseLo, ~cqBase[31:0], 4'b0011);
      readCheck(RegIrrqBaseHi, irrqBase[63:32]);
      readCheck(RegIrrqBaseLo, irrqBase[31:0]);
      readCheck(RegCqBaseHi, cqBase[63:32]);
      readCheck(RegCqBaseLo, cqBase[31:0]);
      readCheck(8'h40, 32'h0);

      runTraffic(IrrqRecords, 0);
      runTraffic(0, CqRecords);
      readCheck(RegIndex, {16'(cqIdx), 16'(irrqIdx)});
      runTraffic(MixRecords, MixRecords);
      floodCheck();
      readCheck(RegIndex, {16'(cqIdx), 16'(irrqIdx)});

      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire
